//--- src/game_pkg.sv
package game_pkg;

    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_sig_t;

    typedef enum logic [1:0] {
        IDLE,
        CHARGING,
        THROWN
    } throw_state_t;

    localparam logic [10:0] H_ACTIVE   = 11'd640;
    localparam logic [10:0] H_FP_END   = 11'd656;
    localparam logic [10:0] H_SYNC_END = 11'd752;
    localparam logic [10:0] H_TOTAL    = 11'd800;

    localparam logic [10:0] V_ACTIVE   = 11'd480;
    localparam logic [10:0] V_FP_END   = 11'd490;
    localparam logic [10:0] V_SYNC_END = 11'd492;
    localparam logic [10:0] V_TOTAL    = 11'd525;

    localparam logic [10:0] GROUND_Y   = 11'd440; // First ground line.
    localparam logic [11:0] RGB_SKY    = 12'h8CF;
    localparam logic [11:0] RGB_GROUND = 12'h383;
    localparam logic [11:0] RGB_BAR    = 12'hF00;
    localparam logic [11:0] RGB_BORDER = 12'h000;

    localparam logic [10:0] BAR_X         = 11'd20;
    localparam logic [10:0] BAR_Y_START   = 11'd400;
    localparam logic [10:0] BAR_Y_END     = 11'd421; // Exclusive.
    localparam logic [7:0]  BAR_MAX_WIDTH = 8'd128;
    localparam logic [10:0] BAR_BORDER    = 11'd3;

    localparam int STEP_INTERVAL_DEFAULT = 1_234_177; // Clocks per bar step on the board.

endpackage

//--- src/vga_timing.sv
`timescale 1ns/1ns

module vga_timing (
    input  logic              clk,
    input  logic              rst,
    output game_pkg::vga_sig_t vga
);

    import game_pkg::*;

    logic [10:0] hcount;
    logic [10:0] vcount;
    logic [10:0] hcount_nxt;
    logic [10:0] vcount_nxt;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    logic        h_last;

    assign h_last     = (hcount == H_TOTAL - 11'd1);
    assign hcount_nxt = h_last ? 11'd0 : hcount + 11'd1;

    always_comb begin
        vcount_nxt = vcount;
        if (h_last) begin
            vcount_nxt = (vcount == V_TOTAL - 11'd1) ? 11'd0 : vcount + 11'd1;
        end
    end

    // Sync and blanking are decoded from the next count so they line up with it.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount <= 11'd0;
            vcount <= 11'd0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hsync  <= (hcount_nxt >= H_FP_END) && (hcount_nxt < H_SYNC_END);
            vsync  <= (vcount_nxt >= V_FP_END) && (vcount_nxt < V_SYNC_END);
            hblnk  <= (hcount_nxt >= H_ACTIVE);
            vblnk  <= (vcount_nxt >= V_ACTIVE);
        end
    end

    always_comb begin
        vga.hcount = hcount;
        vga.vcount = vcount;
        vga.hsync  = hsync;
        vga.vsync  = vsync;
        vga.hblnk  = hblnk;
        vga.vblnk  = vblnk;
        vga.rgb    = 12'h000; // Colour is added downstream.
    end

endmodule

//--- src/background_draw.sv
`timescale 1ns/1ns

module background_draw (
    input  logic               clk,
    input  logic               rst,
    input  game_pkg::vga_sig_t vga_in,
    output game_pkg::vga_sig_t vga_out
);

    import game_pkg::*;

    logic [11:0] rgb_nxt;

    always_comb begin
        if (vga_in.hblnk || vga_in.vblnk) begin
            rgb_nxt = 12'h000;
        end else if (vga_in.vcount < GROUND_Y) begin
            rgb_nxt = RGB_SKY;
        end else begin
            rgb_nxt = RGB_GROUND;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= rgb_nxt; // Overrides the incoming colour.
        end
    end

endmodule

//--- src/throw_fsm.sv
`timescale 1ns/1ns

module throw_fsm (
    input  logic       clk,
    input  logic       rst,
    input  logic       space,
    input  logic [7:0] bar_width,
    output logic       charging,
    output logic       throw_valid,
    output logic [7:0] throw_force
);

    import game_pkg::*;

    throw_state_t state;
    throw_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (space) begin
                    state_nxt = CHARGING;
                end
            end
            CHARGING: begin
                if (!space) begin
                    state_nxt = THROWN;
                end
            end
            THROWN:  state_nxt = IDLE; // Key is looked at again from IDLE.
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            throw_force <= 8'd0;
        end else begin
            state <= state_nxt;
            if (state == CHARGING && !space) begin
                throw_force <= bar_width; // Latched on release.
            end
        end
    end

    assign charging    = (state == CHARGING);
    assign throw_valid = (state == THROWN); // One cycle, with the new force.

endmodule

//--- src/charge_timer.sv
`timescale 1ns/1ns

module charge_timer #(
    parameter int STEP_INTERVAL = game_pkg::STEP_INTERVAL_DEFAULT
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       charging,
    output logic [7:0] bar_width
);

    import game_pkg::*;

    logic [31:0] step_cnt;
    logic        step_done;

    assign step_done = (step_cnt == 32'(STEP_INTERVAL));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step_cnt  <= 32'd0;
            bar_width <= 8'd0;
        end else if (!charging) begin
            step_cnt  <= 32'd0;
            bar_width <= 8'd0;
        end else if (bar_width < BAR_MAX_WIDTH) begin
            if (step_done) begin
                step_cnt  <= 32'd0;
                bar_width <= bar_width + 8'd1;
            end else begin
                step_cnt <= step_cnt + 32'd1;
            end
        end
        // Full bar holds until the key goes up
    end

endmodule

//--- src/power_bar_draw.sv
`timescale 1ns/1ns

module power_bar_draw (
    input  logic               charging,
    input  logic [7:0]         bar_width,
    input  game_pkg::vga_sig_t vga_in,
    output game_pkg::vga_sig_t vga_out
);

    import game_pkg::*;

    logic [10:0] fill_x_end;
    logic [10:0] box_x_end;
    logic        in_fill;
    logic        in_outer;
    logic        in_inner;
    logic        in_border;

    assign fill_x_end = BAR_X + 11'(bar_width);
    assign box_x_end  = BAR_X + 11'(BAR_MAX_WIDTH);

    assign in_fill = charging &&
                     (vga_in.hcount >= BAR_X) && (vga_in.hcount < fill_x_end) &&
                     (vga_in.vcount >= BAR_Y_START) && (vga_in.vcount < BAR_Y_END);

    // Outer edge of the frame.
    assign in_outer = (vga_in.hcount >= BAR_X - BAR_BORDER) &&
                      (vga_in.hcount < box_x_end + BAR_BORDER) &&
                      (vga_in.vcount >= BAR_Y_START - BAR_BORDER) &&
                      (vga_in.vcount < BAR_Y_END + BAR_BORDER);

    // Full box the bar can fill.
    assign in_inner = (vga_in.hcount >= BAR_X) && (vga_in.hcount < box_x_end) &&
                      (vga_in.vcount >= BAR_Y_START) && (vga_in.vcount < BAR_Y_END);

    assign in_border = charging && in_outer && !in_inner;

    always_comb begin
        vga_out = vga_in;
        if (in_fill) begin
            vga_out.rgb = RGB_BAR;
        end else if (in_border) begin
            vga_out.rgb = RGB_BORDER;
        end
    end

endmodule

//--- src/throw_game_top.sv
`timescale 1ns/1ns

module throw_game_top #(
    parameter int STEP_INTERVAL = game_pkg::STEP_INTERVAL_DEFAULT
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               space,
    output game_pkg::vga_sig_t vga_out,
    output logic               throw_valid,
    output logic [7:0]         throw_force
);

    import game_pkg::*;

    vga_sig_t   vga_timing_out;
    vga_sig_t   vga_bg_out; // Lags the counters by one clock.
    logic       charging;
    logic [7:0] bar_width;

    vga_timing u_vga_timing (
        .clk (clk),
        .rst (rst),
        .vga (vga_timing_out)
    );

    background_draw u_background_draw (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (vga_timing_out),
        .vga_out (vga_bg_out)
    );

    throw_fsm u_throw_fsm (
        .clk         (clk),
        .rst         (rst),
        .space       (space),
        .bar_width   (bar_width),
        .charging    (charging),
        .throw_valid (throw_valid),
        .throw_force (throw_force)
    );

    charge_timer #(
        .STEP_INTERVAL (STEP_INTERVAL)
    ) u_charge_timer (
        .clk       (clk),
        .rst       (rst),
        .charging  (charging),
        .bar_width (bar_width)
    );

    power_bar_draw u_power_bar_draw (
        .charging  (charging),
        .bar_width (bar_width),
        .vga_in    (vga_bg_out),
        .vga_out   (vga_out)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

//--- test/throw_game_tb.sv
`timescale 1ns/1ns

module throw_game_tb;

    import game_pkg::*;

    localparam int STEP_INTERVAL = 3;
    localparam int CLK_PERIOD_NS = 8;
    localparam int SEED          = 76611;
    localparam int WATCHDOG_NS   = 3 * int'(H_TOTAL) * int'(V_TOTAL) * CLK_PERIOD_NS + 100_000;

    typedef enum logic [1:0] {KEY_UP, KEY_HELD, KEY_RELEASED} model_state_t;

    logic         clk;
    logic         rst;
    logic         space;
    vga_sig_t     vga_out;
    logic         throw_valid;
    logic [7:0]   throw_force;
    vga_sig_t     prev_vga;
    model_state_t model_state;
    int           model_cycles;
    logic [7:0]   model_force;
    logic [7:0]   exp_width;
    logic         model_charging;
    logic [10:0]  exp_hcount;
    logic [10:0]  exp_vcount;
    logic         exp_hsync;
    logic         exp_vsync;
    logic         exp_hblnk;
    logic         exp_vblnk;
    logic [11:0]  exp_rgb;
    int           settle_cnt;
    logic         checks_on;
    int           errors;
    int           throws_sent;
    int           throws_seen;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) u_tb_clock (.clk(clk));

    throw_game_top #(.STEP_INTERVAL(STEP_INTERVAL)) u_throw_game_top (
        .clk         (clk),
        .rst         (rst),
        .space       (space),
        .vga_out     (vga_out),
        .throw_valid (throw_valid),
        .throw_force (throw_force)
    );

    function automatic logic [11:0] expected_rgb(input vga_sig_t px, input logic chg,
                                                 input int width);
        int  x;
        int  y;
        logic in_box;
        logic in_frame;
        x = int'(px.hcount);
        y = int'(px.vcount);
        in_box   = x >= int'(BAR_X) && x < int'(BAR_X) + int'(BAR_MAX_WIDTH) &&
                   y >= int'(BAR_Y_START) && y < int'(BAR_Y_END);
        in_frame = x >= int'(BAR_X) - int'(BAR_BORDER) &&
                   x < int'(BAR_X) + int'(BAR_MAX_WIDTH) + int'(BAR_BORDER) &&
                   y >= int'(BAR_Y_START) - int'(BAR_BORDER) &&
                   y < int'(BAR_Y_END) + int'(BAR_BORDER);
        if (chg && in_box && x < int'(BAR_X) + width) return RGB_BAR;
        if (chg && in_frame && !in_box) return RGB_BORDER;
        if (x >= int'(H_ACTIVE) || y >= int'(V_ACTIVE)) return 12'h000;
        return (y < int'(GROUND_Y)) ? RGB_SKY : RGB_GROUND;
    endfunction

    task automatic report_mismatch(input string detail);
        errors++;
        $display("CHECK FAILED %s", detail);
    endtask

    // Key model, stepped on the same edges as the DUT.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            model_state  <= KEY_UP;
            model_cycles <= 0;
            model_force  <= 8'd0;
        end else begin
            case (model_state)
                KEY_UP:   if (space) model_state <= KEY_HELD;
                KEY_HELD: begin
                    model_cycles <= model_cycles + 1;
                    if (!space) begin
                        model_state <= KEY_RELEASED;
                        model_force <= exp_width;
                    end
                end
                default:  model_state <= KEY_UP;
            endcase
            if (model_state != KEY_HELD) model_cycles <= 0;
        end
    end

    assign model_charging = (model_state == KEY_HELD);
    assign exp_width = (model_cycles / (STEP_INTERVAL + 1) >= int'(BAR_MAX_WIDTH)) ?
                       BAR_MAX_WIDTH : 8'(model_cycles / (STEP_INTERVAL + 1));

    always @(posedge clk or posedge rst) begin
        if (rst) settle_cnt <= 0;
        else if (settle_cnt < 3) settle_cnt <= settle_cnt + 1;
    end

    always @(posedge clk) prev_vga <= vga_out;
    always @(negedge clk) if (throw_valid) throws_seen++;

    assign checks_on  = (settle_cnt == 3); // Stream is settled past the reset sample.
    assign exp_hcount = (prev_vga.hcount == H_TOTAL - 11'd1) ? 11'd0 : prev_vga.hcount + 11'd1;
    assign exp_vcount = (prev_vga.hcount != H_TOTAL - 11'd1) ? prev_vga.vcount :
                        (prev_vga.vcount == V_TOTAL - 11'd1) ? 11'd0 : prev_vga.vcount + 11'd1;
    assign exp_hsync  = (vga_out.hcount >= H_FP_END) && (vga_out.hcount < H_SYNC_END);
    assign exp_vsync  = (vga_out.vcount >= V_FP_END) && (vga_out.vcount < V_SYNC_END);
    assign exp_hblnk  = (vga_out.hcount >= H_ACTIVE);
    assign exp_vblnk  = (vga_out.vcount >= V_ACTIVE);
    assign exp_rgb    = expected_rgb(vga_out, model_charging, int'(exp_width));

    assert property (@(posedge clk) $past(rst) |-> vga_out == '0)
        else report_mismatch($sformatf("vga_out got %h expected 0", $sampled(vga_out)));
    assert property (@(posedge clk) $past(rst) |-> !throw_valid)
        else report_mismatch($sformatf("throw_valid got %h expected 0", $sampled(throw_valid)));
    assert property (@(posedge clk) $past(rst) |-> throw_force == 8'd0)
        else report_mismatch($sformatf("throw_force got %h expected 0", $sampled(throw_force)));
    assert property (@(posedge clk) disable iff (!checks_on) vga_out.hcount == exp_hcount)
        else report_mismatch($sformatf("hcount got %h expected %h",
                             $sampled(vga_out.hcount), $sampled(exp_hcount)));
    assert property (@(posedge clk) disable iff (!checks_on) vga_out.vcount == exp_vcount)
        else report_mismatch($sformatf("vcount got %h expected %h",
                             $sampled(vga_out.vcount), $sampled(exp_vcount)));
    assert property (@(posedge clk) disable iff (!checks_on) vga_out.hsync == exp_hsync)
        else report_mismatch($sformatf("hsync got %h expected %h",
                             $sampled(vga_out.hsync), $sampled(exp_hsync)));
    assert property (@(posedge clk) disable iff (!checks_on) vga_out.vsync == exp_vsync)
        else report_mismatch($sformatf("vsync got %h expected %h",
                             $sampled(vga_out.vsync), $sampled(exp_vsync)));
    assert property (@(posedge clk) disable iff (!checks_on) vga_out.hblnk == exp_hblnk)
        else report_mismatch($sformatf("hblnk got %h expected %h",
                             $sampled(vga_out.hblnk), $sampled(exp_hblnk)));
    assert property (@(posedge clk) disable iff (!checks_on) vga_out.vblnk == exp_vblnk)
        else report_mismatch($sformatf("vblnk got %h expected %h",
                             $sampled(vga_out.vblnk), $sampled(exp_vblnk)));
    assert property (@(posedge clk) disable iff (!checks_on) vga_out.rgb == exp_rgb)
        else report_mismatch($sformatf("rgb got %h expected %h at %h,%h", $sampled(vga_out.rgb),
                             $sampled(exp_rgb), $sampled(vga_out.hcount), $sampled(vga_out.vcount)));
    assert property (@(posedge clk) disable iff (rst) u_throw_game_top.bar_width == exp_width)
        else report_mismatch($sformatf("bar_width got %h expected %h",
                             $sampled(u_throw_game_top.bar_width), $sampled(exp_width)));
    assert property (@(posedge clk) disable iff (rst)
                     $rose(model_charging) |-> u_throw_game_top.bar_width == 8'd0)
        else report_mismatch($sformatf("bar_width at press got %h expected 0",
                             $sampled(u_throw_game_top.bar_width)));
    assert property (@(posedge clk) disable iff (rst) throw_valid == (model_state == KEY_RELEASED))
        else report_mismatch($sformatf("throw_valid got %h expected %h", $sampled(throw_valid),
                             $sampled(model_state == KEY_RELEASED)));
    assert property (@(posedge clk) disable iff (rst) throw_valid |=> !throw_valid)
        else report_mismatch("throw_valid got 1 expected 0 after one cycle");
    assert property (@(posedge clk) disable iff (rst) throw_force == model_force)
        else report_mismatch($sformatf("throw_force got %h expected %h",
                             $sampled(throw_force), $sampled(model_force)));
    assert property (@(posedge clk) disable iff (rst)
                     throw_valid && model_cycles > 129 * (STEP_INTERVAL + 1) |-> throw_force == 8'd128)
        else report_mismatch($sformatf("throw_force got %h expected 80", $sampled(throw_force)));

    task automatic wait_for_pixel(input logic [10:0] v, input logic [10:0] h);
        @(negedge clk);
        while (vga_out.vcount != v || vga_out.hcount != h) @(negedge clk);
    endtask

    task automatic press_key(input int cycles);
        @(posedge clk);
        space <= 1'b1;
        repeat (cycles) @(posedge clk);
        space <= 1'b0;
        throws_sent++;
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    initial begin
        rst         = 1'b1;
        space       = 1'b0;
        errors      = 0;
        throws_sent = 0;
        throws_seen = 0;
        void'($urandom(SEED));
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        wait_for_pixel(V_TOTAL - 11'd1, H_TOTAL - 11'd1); // Whole first frame with the key up.
        wait_for_pixel(BAR_Y_START, 11'd0);
        for (int i = 0; i < 4; i++) begin
            press_key(1 + $urandom % 300);
            idle_cycles(3 + $urandom % 40);
        end
        press_key(520 + $urandom % 200); // Saturates the bar.
        idle_cycles(3 + $urandom % 40);
        press_key(1);
        idle_cycles(3 + $urandom % 40);
        press_key(1 + $urandom % 100);
        idle_cycles(20);
        if (throws_seen != throws_sent) begin
            errors++;
            $display("Wrong number of throws: %0d pressed, %0d seen", throws_sent, throws_seen);
        end
        $display("Summary: %0d throws, %0d errors", throws_seen, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within three frames");
        $display("Test failed");
        $finish;
    end

endmodule

//--- throw_game.f
src/game_pkg.sv
src/vga_timing.sv
src/background_draw.sv
src/throw_fsm.sv
src/charge_timer.sv
src/power_bar_draw.sv
src/throw_game_top.sv
test/tb_clock.sv
test/throw_game_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= throw_game_tb
RTL_TOP    ?= throw_game_top
FILELIST   ?= throw_game.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Test completed successfully
LINT_FLAGS ?= --lint-only -Wall --timescale 1ns/1ns
SIM_FLAGS  ?= --binary --timing --assert --timescale 1ns/1ns

RTL_SRCS = $(shell grep '^src/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
